// ==== vlog.f ====
isa_pkg.sv
core_pkg.sv
id_decoder.sv
regfile.sv
exe_alu.sv
wb_result.sv
la_exec_top.sv
tb_la_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run tb_la_exec with Verilator, then judge the run from sim.log
rm -f sim.log build.log
verilator --binary --timing --assert -j 0 -Wno-fatal --top-module tb_la_exec \
    -f vlog.f -o tb_la_exec_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_la_exec_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

// ==== tb_la_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_la_exec
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int SEED       = 71844;
    // 1 + 12 + 68 + 3 + 10 + 8 handshakes over all tests
    localparam int HANDSHAKES = 102;
    localparam int MAX_CYCLES = HANDSHAKES * 8 + 200;

    localparam logic [16:0] OPS_3R [7] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
                                           OP_AND, OP_OR, OP_XOR};
    localparam logic [9:0] OPS_RI12 [5] = '{OP_ADDI_W, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI};

    logic       clk = 1'b0;
    logic       rst;
    logic       req;
    word_t      instr;
    word_t      pc;
    logic       has_int;
    logic       fetch_excp;
    logic       ack;
    logic       wb_valid;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       excp;
    excp_vec_t  excp_vec;
    excp_code_e excp_code;

    // Outputs sampled at ack
    logic       got_valid;
    reg_addr_t  got_addr;
    word_t      got_data;
    logic       got_excp;
    excp_vec_t  got_vec;
    excp_code_e got_code;

    word_t regs_m [32];
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;

    la_exec_top DUT (
        .clk(clk), .rst_i(rst), .req_i(req), .instr_i(instr), .pc_i(pc),
        .has_int_i(has_int), .fetch_excp_i(fetch_excp), .ack_o(ack),
        .wb_valid_o(wb_valid), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
        .excp_o(excp), .excp_vec_o(excp_vec), .excp_code_o(excp_code)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic word_t r3_word(logic [16:0] op, reg_addr_t rk, reg_addr_t rj,
                                      reg_addr_t rd);
        instr_fmt_u u;
        u.r3.opcode = op;
        u.r3.rk     = rk;
        u.r3.rj     = rj;
        u.r3.rd     = rd;
        return u;
    endfunction

    function automatic word_t ri12_word(logic [9:0] op, logic [11:0] imm, reg_addr_t rj,
                                        reg_addr_t rd);
        instr_fmt_u u;
        u.ri12.opcode = op;
        u.ri12.imm    = imm;
        u.ri12.rj     = rj;
        u.ri12.rd     = rd;
        return u;
    endfunction

    function automatic word_t ri20_word(logic [6:0] op, logic [19:0] imm, reg_addr_t rd);
        instr_fmt_u u;
        u.ri20.opcode = op;
        u.ri20.imm    = imm;
        u.ri20.rd     = rd;
        return u;
    endfunction

    function automatic word_t model_3r(logic [16:0] op, word_t a, word_t b);
        case (op)
            OP_ADD_W: return a + b;
            OP_SUB_W: return a - b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
            OP_SLTU:  return (a < b) ? 32'h1 : 32'h0;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            default:  return 32'h0;
        endcase
    endfunction

    // Arithmetic immediates sign-extend, logical ones zero-extend
    function automatic word_t model_ri12(logic [9:0] op, word_t a, logic [11:0] imm);
        word_t sx;
        word_t zx;
        sx = {{20{imm[11]}}, imm};
        zx = {20'h0, imm};
        case (op)
            OP_ADDI_W: return a + sx;
            OP_SLTI:   return ($signed(a) < $signed(sx)) ? 32'h1 : 32'h0;
            OP_ANDI:   return a & zx;
            OP_ORI:    return a | zx;
            OP_XORI:   return a ^ zx;
            default:   return 32'h0;
        endcase
    endfunction

    // Full four-phase handshake, optionally holding req past ack
    task automatic send_instr(input word_t ins, input word_t pc_v, input logic intr,
                              input logic fexc, input int hold);
        @(negedge clk);
        instr      = ins;
        pc         = pc_v;
        has_int    = intr;
        fetch_excp = fexc;
        req        = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        got_valid = wb_valid;
        got_addr  = wb_addr;
        got_data  = wb_data;
        got_excp  = excp;
        got_vec   = excp_vec;
        got_code  = excp_code;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_eq("ack_o held", 32'(ack), 32'h1);
            check_eq("wb_valid_o held", 32'(wb_valid), 32'(got_valid));
            check_eq("wb_data_o held", wb_data, got_data);
            check_eq("excp_o held", 32'(excp), 32'(got_excp));
        end
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
        has_int    = 1'b0;
        fetch_excp = 1'b0;
    endtask

    task automatic expect_write(input reg_addr_t rd, input word_t value);
        check_eq("wb_valid_o", 32'(got_valid), 32'h1);
        check_eq("excp_o", 32'(got_excp), 32'h0);
        check_eq("excp_code_o", 32'(got_code), 32'(ECODE_NONE));
        check_eq("wb_addr_o", 32'(got_addr), 32'(rd));
        check_eq("wb_data_o", got_data, value);
        if (rd != 5'd0) begin
            regs_m[rd] = value;
        end
    endtask

    task automatic expect_excp(input excp_vec_t vec, input excp_code_e code);
        check_eq("excp_o", 32'(got_excp), 32'h1);
        check_eq("wb_valid_o", 32'(got_valid), 32'h0);
        check_eq("excp_vec_o", 32'(got_vec), 32'(vec));
        check_eq("excp_code_o", 32'(got_code), 32'(code));
    endtask

    task automatic load_reg(input reg_addr_t rd, input word_t value);
        send_instr(ri20_word(OP_LU12I_W, value[31:12], rd), 32'h0, 1'b0, 1'b0, 0);
        expect_write(rd, {value[31:12], 12'h000});
        send_instr(ri12_word(OP_ORI, value[11:0], rd, rd), 32'h0, 1'b0, 1'b0, 0);
        expect_write(rd, {value[31:12], 12'h000} | {20'h0, value[11:0]});
    endtask

    // ADD.W into r0 reports the value without changing any register
    task automatic read_back(input reg_addr_t rj);
        send_instr(r3_word(OP_ADD_W, 5'd0, rj, 5'd0), 32'h0, 1'b0, 1'b0, 0);
        expect_write(5'd0, (rj == 5'd0) ? 32'h0 : regs_m[rj]);
    endtask

    task automatic reset_and_handshake();
        logic [19:0] imm;
        int          edges;
        imm = 20'($urandom);
        check_eq("ack_o after reset", 32'(ack), 32'h0);
        check_eq("wb_valid_o after reset", 32'(wb_valid), 32'h0);
        check_eq("excp_o after reset", 32'(excp), 32'h0);
        @(negedge clk);
        instr = ri20_word(OP_LU12I_W, imm, 5'd1);
        req   = 1'b1;
        edges = 0;
        @(negedge clk);
        while (!ack) begin
            edges++;
            @(negedge clk);
        end
        check_eq("ack_o delay in edges", 32'(edges), 32'd2);
        check_eq("wb_valid_o", 32'(wb_valid), 32'h1);
        check_eq("wb_addr_o", 32'(wb_addr), 32'h1);
        check_eq("wb_data_o", wb_data, {imm, 12'h000});
        regs_m[1] = {imm, 12'h000};
        req = 1'b0;
        @(negedge clk);
        check_eq("ack_o after req low", 32'(ack), 32'h0);
    endtask

    task automatic immediate_loads();
        for (int r = 8; r < 12; r++) begin
            load_reg(reg_addr_t'(r), $urandom);
        end
        for (int r = 8; r < 12; r++) begin
            read_back(reg_addr_t'(r));
        end
    endtask

    task automatic alu_ops();
        word_t       a;
        word_t       b;
        word_t       pcv;
        logic [11:0] imm12;
        logic [19:0] imm20;
        for (int it = 0; it < 4; it++) begin
            a = $urandom;
            b = $urandom;
            // Opposite signs make SLT and SLTU disagree
            if (it == 0) begin
                a[31] = 1'b1;
                b[31] = 1'b0;
            end else if (it == 1) begin
                a[31] = 1'b0;
                b[31] = 1'b1;
            end else if (it == 2) begin
                b = a;
            end
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (int i = 0; i < 7; i++) begin
                send_instr(r3_word(OPS_3R[i], 5'd2, 5'd1, 5'd3), 32'h0, 1'b0, 1'b0, 0);
                expect_write(5'd3, model_3r(OPS_3R[i], a, b));
            end
            for (int i = 0; i < 5; i++) begin
                imm12     = 12'($urandom);
                imm12[11] = (it % 2 == 0);
                send_instr(ri12_word(OPS_RI12[i], imm12, 5'd1, 5'd3), 32'h0, 1'b0, 1'b0, 0);
                expect_write(5'd3, model_ri12(OPS_RI12[i], a, imm12));
            end
            pcv   = $urandom & 32'hFFFF_FFFC;
            imm20 = 20'($urandom);
            send_instr(ri20_word(OP_PCADDU12I, imm20, 5'd4), pcv, 1'b0, 1'b0, 0);
            expect_write(5'd4, pcv + {imm20, 12'h000});
        end
    endtask

    task automatic r0_discard();
        logic [19:0] imm20;
        imm20 = 20'($urandom) | 20'h1;
        send_instr(ri20_word(OP_LU12I_W, imm20, 5'd0), 32'h0, 1'b0, 1'b0, 0);
        expect_write(5'd0, {imm20, 12'h000});
        send_instr(ri12_word(OP_ORI, 12'hABC, 5'd0, 5'd0), 32'h0, 1'b0, 1'b0, 0);
        expect_write(5'd0, 32'h0000_0ABC);
        read_back(5'd0);
    endtask

    task automatic exceptions();
        word_t syscall_w;
        word_t break_w;
        syscall_w = {OP_SYSCALL, 15'($urandom)};
        break_w   = {OP_BREAK, 15'($urandom)};
        load_reg(5'd6, $urandom);
        // Vector bits are INE, BRK, SYS, ADEF, INT from msb down
        send_instr(syscall_w, 32'h0, 1'b0, 1'b0, 0);
        expect_excp(5'b00100, ECODE_SYS);
        send_instr(break_w, 32'h0, 1'b0, 1'b0, 0);
        expect_excp(5'b01000, ECODE_BRK);
        send_instr(32'hFFFF_FFFF, 32'h0, 1'b0, 1'b0, 0);
        expect_excp(5'b10000, ECODE_INE);
        send_instr(r3_word(OP_ADD_W, 5'd0, 5'd0, 5'd6), 32'h0, 1'b1, 1'b0, 0);
        expect_excp(5'b00001, ECODE_INT);
        send_instr(ri12_word(OP_ADDI_W, 12'h001, 5'd6, 5'd6), 32'h0, 1'b0, 1'b1, 0);
        expect_excp(5'b00010, ECODE_ADEF);
        send_instr(syscall_w, 32'h0, 1'b1, 1'b1, 0);
        expect_excp(5'b00111, ECODE_INT);
        send_instr(32'hFFFF_FFFF, 32'h0, 1'b0, 1'b1, 0);
        expect_excp(5'b10010, ECODE_ADEF);
        read_back(5'd6);
    endtask

    // A second capture of ADDI would add one twice
    task automatic back_pressure();
        word_t v;
        int    hold;
        for (int n = 0; n < 2; n++) begin
            v    = $urandom;
            hold = $urandom_range(9, 2);
            load_reg(5'd7, v);
            send_instr(ri12_word(OP_ADDI_W, 12'h001, 5'd7, 5'd7), 32'h0, 1'b0, 1'b0, hold);
            expect_write(5'd7, v + 32'h1);
            read_back(5'd7);
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = 1'b0;
        instr      = '0;
        pc         = '0;
        has_int    = 1'b0;
        fetch_excp = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        void'($urandom(SEED));
        repeat (3) @(negedge clk);
        rst = 1'b0;

        reset_and_handshake();
        immediate_loads();
        alu_ops();
        r0_discard();
        exceptions();
        back_pressure();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== la_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module la_exec_top
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire             req_i,
    input  wire word_t      instr_i,
    input  wire word_t      pc_i,
    input  wire             has_int_i,
    input  wire             fetch_excp_i,
    output logic            ack_o,
    output logic            wb_valid_o,
    output reg_addr_t       wb_addr_o,
    output word_t           wb_data_o,
    output logic            excp_o,
    output excp_vec_t       excp_vec_o,
    output excp_code_e      excp_code_o
);

    // Decode to execute
    logic       issue_valid;
    alu_op_e    aluop;
    reg_addr_t  rj_addr, rk_addr, id_rd_addr;
    logic       use_imm, id_rd_we;
    word_t      imm, id_pc;
    excp_vec_t  id_excp_vec;

    // Register file ports
    reg_addr_t  ra_addr, rb_addr, rf_waddr;
    word_t      ra_data, rb_data, rf_wdata;
    logic       rf_we;

    // Execute to write-back
    logic       exe_valid, exe_rd_we;
    word_t      exe_result;
    reg_addr_t  exe_rd_addr;
    excp_vec_t  exe_excp_vec;

    id_decoder u_id_decoder (
        .clk(clk), .rst_i(rst_i), .req_i(req_i), .instr_i(instr_i), .pc_i(pc_i),
        .has_int_i(has_int_i), .fetch_excp_i(fetch_excp_i), .ack_i(ack_o),
        .issue_valid_o(issue_valid), .aluop_o(aluop), .rj_addr_o(rj_addr),
        .rk_addr_o(rk_addr), .use_imm_o(use_imm), .imm_o(imm), .rd_addr_o(id_rd_addr),
        .rd_we_o(id_rd_we), .pc_o(id_pc), .excp_vec_o(id_excp_vec)
    );

    regfile u_regfile (
        .clk(clk), .rst_i(rst_i), .ra_addr_i(ra_addr), .rb_addr_i(rb_addr),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .ra_data_o(ra_data), .rb_data_o(rb_data)
    );

    exe_alu u_exe_alu (
        .clk(clk), .rst_i(rst_i), .issue_valid_i(issue_valid), .aluop_i(aluop),
        .rj_addr_i(rj_addr), .rk_addr_i(rk_addr), .use_imm_i(use_imm), .imm_i(imm),
        .rd_addr_i(id_rd_addr), .rd_we_i(id_rd_we), .pc_i(id_pc), .excp_vec_i(id_excp_vec),
        .ra_data_i(ra_data), .rb_data_i(rb_data), .ra_addr_o(ra_addr), .rb_addr_o(rb_addr),
        .exe_valid_o(exe_valid), .result_o(exe_result), .rd_addr_o(exe_rd_addr),
        .rd_we_o(exe_rd_we), .excp_vec_o(exe_excp_vec)
    );

    wb_result u_wb_result (
        .clk(clk), .rst_i(rst_i), .exe_valid_i(exe_valid), .result_i(exe_result),
        .rd_addr_i(exe_rd_addr), .rd_we_i(exe_rd_we), .excp_vec_i(exe_excp_vec),
        .req_i(req_i), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .ack_o(ack_o), .wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o),
        .wb_data_o(wb_data_o), .excp_o(excp_o), .excp_vec_o(excp_vec_o),
        .excp_code_o(excp_code_o)
    );

endmodule

`default_nettype wire

// ==== wb_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_result
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire             exe_valid_i,
    input  wire word_t      result_i,
    input  wire reg_addr_t  rd_addr_i,
    input  wire             rd_we_i,
    input  wire excp_vec_t  excp_vec_i,
    input  wire             req_i,
    output logic            rf_we_o,
    output reg_addr_t       rf_waddr_o,
    output word_t           rf_wdata_o,
    output logic            ack_o,
    output logic            wb_valid_o,
    output reg_addr_t       wb_addr_o,
    output word_t           wb_data_o,
    output logic            excp_o,
    output excp_vec_t       excp_vec_o,
    output excp_code_e      excp_code_o
);

    excp_code_e code;

    // Register file write lands on the same edge as ack
    assign rf_we_o    = exe_valid_i && rd_we_i;
    assign rf_waddr_o = rd_addr_i;
    assign rf_wdata_o = result_i;

    always_comb begin
        if (excp_vec_i[EXC_INT]) begin
            code = ECODE_INT;
        end else if (excp_vec_i[EXC_ADEF]) begin
            code = ECODE_ADEF;
        end else if (excp_vec_i[EXC_INE]) begin
            code = ECODE_INE;
        end else if (excp_vec_i[EXC_SYS]) begin
            code = ECODE_SYS;
        end else if (excp_vec_i[EXC_BRK]) begin
            code = ECODE_BRK;
        end else begin
            code = ECODE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o       <= 1'b0;
            wb_valid_o  <= 1'b0;
            excp_o      <= 1'b0;
            excp_vec_o  <= '0;
            excp_code_o <= ECODE_NONE;
        end else begin
            if (exe_valid_i) begin
                ack_o       <= 1'b1;
                wb_valid_o  <= rd_we_i;
                excp_o      <= |excp_vec_i;
                excp_vec_o  <= excp_vec_i;
                excp_code_o <= code;
            end else if (ack_o && !req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i) begin
            wb_addr_o <= rd_addr_i;
            wb_data_o <= result_i;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

// ==== exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire             issue_valid_i,
    input  wire alu_op_e    aluop_i,
    input  wire reg_addr_t  rj_addr_i,
    input  wire reg_addr_t  rk_addr_i,
    input  wire             use_imm_i,
    input  wire word_t      imm_i,
    input  wire reg_addr_t  rd_addr_i,
    input  wire             rd_we_i,
    input  wire word_t      pc_i,
    input  wire excp_vec_t  excp_vec_i,
    input  wire word_t      ra_data_i,
    input  wire word_t      rb_data_i,
    output reg_addr_t       ra_addr_o,
    output reg_addr_t       rb_addr_o,
    output logic            exe_valid_o,
    output word_t           result_o,
    output reg_addr_t       rd_addr_o,
    output logic            rd_we_o,
    output excp_vec_t       excp_vec_o
);

    word_t opa;
    word_t opb;
    word_t alu_res;

    assign ra_addr_o = rj_addr_i;
    assign rb_addr_o = rk_addr_i;

    assign opa = ra_data_i;
    assign opb = use_imm_i ? imm_i : rb_data_i;

    always_comb begin
        case (aluop_i)
            ALU_ADD:   alu_res = opa + opb;
            ALU_SUB:   alu_res = opa - opb;
            ALU_SLT:   alu_res = word_t'($signed(opa) < $signed(opb));
            ALU_SLTU:  alu_res = word_t'(opa < opb);
            ALU_AND:   alu_res = opa & opb;
            ALU_OR:    alu_res = opa | opb;
            ALU_XOR:   alu_res = opa ^ opb;
            ALU_LUI:   alu_res = imm_i;
            ALU_PCADD: alu_res = pc_i + imm_i;
            default:   alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exe_valid_o <= 1'b0;
            rd_we_o     <= 1'b0;
            excp_vec_o  <= '0;
        end else begin
            exe_valid_o <= issue_valid_i;
            // A faulting instruction must not retire its result
            rd_we_o     <= issue_valid_i && rd_we_i && (excp_vec_i == '0);
            excp_vec_o  <= issue_valid_i ? excp_vec_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            result_o  <= alu_res;
            rd_addr_o <= rd_addr_i;
        end
    end

    // Decode-side faults never ask for a write
    no_write_on_excp: assert property (@(posedge clk) disable iff (rst_i)
        issue_valid_i && (excp_vec_i[EXC_SYS] || excp_vec_i[EXC_BRK] || excp_vec_i[EXC_INE])
        |-> !rd_we_i);

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire reg_addr_t  ra_addr_i,
    input  wire reg_addr_t  rb_addr_i,
    input  wire             we_i,
    input  wire reg_addr_t  waddr_i,
    input  wire word_t      wdata_i,
    output word_t           ra_data_o,
    output word_t           rb_data_o
);

    word_t regs [REG_NUM];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired
    assign ra_data_o = (ra_addr_i == '0) ? '0 : regs[ra_addr_i];
    assign rb_data_o = (rb_addr_i == '0) ? '0 : regs[rb_addr_i];

endmodule

`default_nettype wire

// ==== id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire             req_i,
    input  wire word_t      instr_i,
    input  wire word_t      pc_i,
    input  wire             has_int_i,
    input  wire             fetch_excp_i,
    input  wire             ack_i,
    output logic            issue_valid_o,
    output alu_op_e         aluop_o,
    output reg_addr_t       rj_addr_o,
    output reg_addr_t       rk_addr_o,
    output logic            use_imm_o,
    output word_t           imm_o,
    output reg_addr_t       rd_addr_o,
    output logic            rd_we_o,
    output word_t           pc_o,
    output excp_vec_t       excp_vec_o
);

    instr_fmt_u instr_q;
    word_t      pc_q;
    logic       int_q;
    logic       adef_q;
    logic       busy_q;
    logic       ack_d;
    logic       capture;

    logic       r3_valid, r3_we, r3_sys, r3_brk;
    alu_op_e    r3_aluop;
    reg_addr_t  r3_rj, r3_rk, r3_rd;

    logic       ri12_valid, ri12_sext;
    alu_op_e    ri12_aluop;
    reg_addr_t  ri12_rj, ri12_rd;
    word_t      ri12_imm;

    logic       ri20_valid;
    alu_op_e    ri20_aluop;
    reg_addr_t  ri20_rd;
    word_t      ri20_imm;

    logic       instr_valid;

    // One instruction in flight
    assign capture = req_i && !busy_q && !ack_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q        <= 1'b0;
            issue_valid_o <= 1'b0;
            ack_d         <= 1'b0;
        end else begin
            issue_valid_o <= capture;
            ack_d         <= ack_i;
            if (capture) begin
                busy_q <= 1'b1;
            end else if (ack_d && !ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q <= instr_i;
            pc_q    <= pc_i;
            int_q   <= has_int_i;
            adef_q  <= fetch_excp_i;
        end
    end

    // 3R
    always_comb begin
        r3_valid = 1'b1;
        r3_we    = 1'b1;
        r3_sys   = 1'b0;
        r3_brk   = 1'b0;
        r3_aluop = ALU_NOP;
        case (instr_q.r3.opcode)
            OP_ADD_W: r3_aluop = ALU_ADD;
            OP_SUB_W: r3_aluop = ALU_SUB;
            OP_SLT:   r3_aluop = ALU_SLT;
            OP_SLTU:  r3_aluop = ALU_SLTU;
            OP_AND:   r3_aluop = ALU_AND;
            OP_OR:    r3_aluop = ALU_OR;
            OP_XOR:   r3_aluop = ALU_XOR;
            OP_SYSCALL: begin
                r3_sys = 1'b1;
                r3_we  = 1'b0;
            end
            OP_BREAK: begin
                r3_brk = 1'b1;
                r3_we  = 1'b0;
            end
            default: begin
                r3_valid = 1'b0;
                r3_we    = 1'b0;
            end
        endcase
        r3_rj = r3_we ? instr_q.r3.rj : '0;
        r3_rk = r3_we ? instr_q.r3.rk : '0;
        r3_rd = r3_we ? instr_q.r3.rd : '0;
    end

    // 2RI12, arithmetic immediates are signed and logical ones unsigned
    always_comb begin
        ri12_valid = 1'b1;
        ri12_sext  = 1'b0;
        ri12_aluop = ALU_NOP;
        case (instr_q.ri12.opcode)
            OP_ADDI_W: begin
                ri12_aluop = ALU_ADD;
                ri12_sext  = 1'b1;
            end
            OP_SLTI: begin
                ri12_aluop = ALU_SLT;
                ri12_sext  = 1'b1;
            end
            OP_ANDI: ri12_aluop = ALU_AND;
            OP_ORI:  ri12_aluop = ALU_OR;
            OP_XORI: ri12_aluop = ALU_XOR;
            default: ri12_valid = 1'b0;
        endcase
        ri12_rj  = ri12_valid ? instr_q.ri12.rj : '0;
        ri12_rd  = ri12_valid ? instr_q.ri12.rd : '0;
        ri12_imm = '0;
        if (ri12_valid) begin
            ri12_imm = {{20{ri12_sext & instr_q.ri12.imm[11]}}, instr_q.ri12.imm};
        end
    end

    // 1RI20
    always_comb begin
        ri20_valid = 1'b1;
        ri20_aluop = ALU_NOP;
        case (instr_q.ri20.opcode)
            OP_LU12I_W:   ri20_aluop = ALU_LUI;
            OP_PCADDU12I: ri20_aluop = ALU_PCADD;
            default:      ri20_valid = 1'b0;
        endcase
        ri20_rd  = ri20_valid ? instr_q.ri20.rd : '0;
        ri20_imm = ri20_valid ? {instr_q.ri20.imm, 12'h000} : '0;
    end

    assign instr_valid = r3_valid | ri12_valid | ri20_valid;

    assign aluop_o   = alu_op_e'(r3_aluop | ri12_aluop | ri20_aluop);
    assign rj_addr_o = r3_rj | ri12_rj;
    assign rk_addr_o = r3_rk;
    assign rd_addr_o = r3_rd | ri12_rd | ri20_rd;
    assign rd_we_o   = r3_we | ri12_valid | ri20_valid;
    assign use_imm_o = ri12_valid | ri20_valid;
    assign imm_o     = ri12_imm | ri20_imm;
    assign pc_o      = pc_q;

    always_comb begin
        excp_vec_o           = '0;
        excp_vec_o[EXC_INT]  = int_q;
        excp_vec_o[EXC_ADEF] = adef_q;
        excp_vec_o[EXC_SYS]  = r3_sys;
        excp_vec_o[EXC_BRK]  = r3_brk;
        excp_vec_o[EXC_INE]  = !instr_valid;
    end

    // Request fields stay put until ack
    req_stable: assert property (@(posedge clk) disable iff (rst_i)
        req_i && $past(req_i) && !ack_i |-> $stable(instr_i) && $stable(pc_i));

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int REG_NUM = 1 << REG_AW;
    localparam int EXC_NUM = 5;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;
    typedef logic [EXC_NUM-1:0] excp_vec_t;

    // One-hot positions in excp_vec_t
    localparam int EXC_INT  = 0;
    localparam int EXC_ADEF = 1;
    localparam int EXC_SYS  = 2;
    localparam int EXC_BRK  = 3;
    localparam int EXC_INE  = 4;

    // Highest-priority cause
    typedef enum logic [2:0] {
        ECODE_NONE = 3'd0,
        ECODE_INT  = 3'd1,
        ECODE_ADEF = 3'd2,
        ECODE_INE  = 3'd3,
        ECODE_SYS  = 3'd4,
        ECODE_BRK  = 3'd5
    } excp_code_e;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Instruction word viewed through each supported format
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm;
            logic [4:0]  rd;
        } ri20;
    } instr_fmt_u;

    // 3R opcodes, bits [31:15]
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_SLTU    = 17'h00025;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002A;
    localparam logic [16:0] OP_XOR     = 17'h0002B;
    // Low 15 bits carry the code field
    localparam logic [16:0] OP_BREAK   = 17'h00054;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;

    // 2RI12 opcodes, bits [31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_ADDI_W = 10'h00A;
    localparam logic [9:0] OP_ANDI   = 10'h00D;
    localparam logic [9:0] OP_ORI    = 10'h00E;
    localparam logic [9:0] OP_XORI   = 10'h00F;

    // 1RI20 opcodes, bits [31:25]
    localparam logic [6:0] OP_LU12I_W   = 7'h0A;
    localparam logic [6:0] OP_PCADDU12I = 7'h0E;

    // NOP must stay zero so sub-decoder outputs can be ORed
    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_AND   = 4'd5,
        ALU_OR    = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_LUI   = 4'd8,
        ALU_PCADD = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire
